/* verilog/vreg_pkg.sv */
package vreg_pkg;

    // lane and register file geometry
    localparam int NUM_LANES         = 4;
    localparam int VREG_LOC_PER_LANE = 8;   // words per register per lane
    localparam int NUM_VREGS         = 8;
    localparam int MEM_DEPTH         = NUM_VREGS * VREG_LOC_PER_LANE;
    localparam int ADDR_W            = $clog2(MEM_DEPTH);
    localparam int LANE_W            = $clog2(NUM_LANES);
    localparam int ELEM_W            = 32;

    // up to 32 byte elements per register per lane
    localparam int CNT_W     = $clog2(VREG_LOC_PER_LANE * 4);
    localparam int GROUP_MAX = 8;
    localparam int STEP_W    = $clog2(GROUP_MAX * VREG_LOC_PER_LANE * 4);

    // last element index inside one register
    localparam int CNT_LIMIT_BYTE = VREG_LOC_PER_LANE * 4 - 1;
    localparam int CNT_LIMIT_HALF = VREG_LOC_PER_LANE * 2 - 1;
    localparam int CNT_LIMIT_WORD = VREG_LOC_PER_LANE - 1;

    typedef enum logic [1:0] {
        ew_byte = 2'b00,
        ew_half = 2'b01,
        ew_word = 2'b10   // 2'b11 unused
    } elem_width_e;

    typedef enum logic {
        dir_down = 1'b0,
        dir_up   = 1'b1
    } walk_dir_e;

    typedef struct packed {
        logic [2:0]           vs;
        logic [2:0]           lmul_m1;
        elem_width_e          ew;
        walk_dir_e            dir;
        logic [NUM_LANES-1:0] lane_mask;
    } vread_cmd_t;

    typedef struct packed {
        logic [LANE_W-1:0] lane;
        logic [ADDR_W-1:0] addr;
        logic [31:0]       data;
    } vwrite_t;

    typedef struct packed {
        logic [NUM_LANES-1:0][ELEM_W-1:0] elem;  // lane 0 in the low word
        logic                             last;
    } vbeat_t;

    typedef logic [GROUP_MAX-1:0][ADDR_W-1:0] start_list_t;

endpackage

/* verilog/vreg_addr_counter.sv */
module vreg_addr_counter (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       load_i,
    input  vreg_pkg::start_list_t      start_list_i,
    input  vreg_pkg::elem_width_e      ew_i,
    input  vreg_pkg::walk_dir_e        dir_i,
    input  logic                       step_i,
    input  logic                       lane_en_i,
    output logic [vreg_pkg::ADDR_W-1:0] addr_o,
    output logic [1:0]                 sub_sel_o
);
    import vreg_pkg::*;

    start_list_t      slot_q;
    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] cnt_limit;
    logic [CNT_W-1:0] cnt_rst;
    logic [CNT_W-1:0] cnt_next;
    logic [CNT_W-1:0] word_off;
    logic             wrap;

    // element limit, word offset and sub-word index per width
    always_comb begin
        case (ew_i)
            ew_byte: begin
                cnt_limit = CNT_W'(CNT_LIMIT_BYTE);
                word_off  = {2'b00, cnt_q[CNT_W-1:2]};
                sub_sel_o = cnt_q[1:0];
            end
            ew_half: begin
                cnt_limit = CNT_W'(CNT_LIMIT_HALF);
                word_off  = {1'b0, cnt_q[CNT_W-1:1]};
                sub_sel_o = {1'b0, cnt_q[0]};
            end
            ew_word: begin
                cnt_limit = CNT_W'(CNT_LIMIT_WORD);
                word_off  = cnt_q;
                sub_sel_o = 2'b00;
            end
            default: begin
                cnt_limit = '0;
                word_off  = '0;
                sub_sel_o = 2'b00;
            end
        endcase
    end

    assign cnt_rst  = (dir_i == dir_up) ? '0 : cnt_limit;
    assign cnt_next = (dir_i == dir_up) ? cnt_q + 1'b1 : cnt_q - 1'b1;
    assign wrap     = (dir_i == dir_up) ? (cnt_q == cnt_limit) : (cnt_q == '0);

    assign addr_o = slot_q[0] + ADDR_W'(word_off);

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            slot_q <= '0;
            cnt_q  <= '0;
        end else if (load_i) begin
            cnt_q <= cnt_rst;
            // down walk takes the highest register first
            for (int i = 0; i < GROUP_MAX; i++) begin
                if (dir_i == dir_up) begin
                    slot_q[i] <= start_list_i[i];
                end else begin
                    slot_q[i] <= start_list_i[GROUP_MAX-1-i];
                end
            end
        end else if (step_i && lane_en_i) begin
            if (wrap) begin
                cnt_q <= cnt_rst;
                for (int i = 0; i < GROUP_MAX - 1; i++) begin
                    slot_q[i] <= slot_q[i+1];   // next register of the group
                end
                slot_q[GROUP_MAX-1] <= '0;
            end else begin
                cnt_q <= cnt_next;
            end
        end
    end

    // the sequencer keeps a gap between load and the first step
    a_no_load_with_step: assert property (
        @(posedge clk_i) disable iff (!rst_i) !(load_i && step_i)
    );

    a_legal_width: assert property (
        @(posedge clk_i) disable iff (!rst_i)
        step_i |-> (ew_i inside {ew_byte, ew_half, ew_word})
    );

endmodule

/* verilog/vreg_lane.sv */
module vreg_lane #(
    parameter int LANE_IDX = 0
) (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        wr_valid_i,
    input  vreg_pkg::vwrite_t           wr_i,
    input  logic                        load_i,
    input  vreg_pkg::start_list_t       start_list_i,
    input  vreg_pkg::elem_width_e       ew_i,
    input  vreg_pkg::walk_dir_e         dir_i,
    input  logic                        step_i,
    input  logic                        lane_en_i,
    output logic [vreg_pkg::ELEM_W-1:0] elem_o,
    output logic                        elem_valid_o
);
    import vreg_pkg::*;

    logic [31:0]       mem [MEM_DEPTH];
    logic [31:0]       rdata_q;
    logic [ADDR_W-1:0] rd_addr;
    logic [1:0]        sub_sel;
    logic [1:0]        sub_sel_q;
    elem_width_e       ew_q;
    logic              valid_q;

    vreg_addr_counter u_addr_counter (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .load_i       (load_i),
        .start_list_i (start_list_i),
        .ew_i         (ew_i),
        .dir_i        (dir_i),
        .step_i       (step_i),
        .lane_en_i    (lane_en_i),
        .addr_o       (rd_addr),
        .sub_sel_o    (sub_sel)
    );

    always_ff @(posedge clk_i) begin
        if (wr_valid_i && (wr_i.lane == LANE_W'(LANE_IDX))) begin
            mem[wr_i.addr] <= wr_i.data;
        end
        rdata_q   <= mem[rd_addr];   // registered read
        sub_sel_q <= sub_sel;
        ew_q      <= ew_i;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= step_i;
        end
    end

    // little-endian pick, zero-extended
    always_comb begin
        case (ew_q)
            ew_byte: elem_o = ELEM_W'(rdata_q[{sub_sel_q, 3'b000} +: 8]);
            ew_half: elem_o = ELEM_W'(rdata_q[{sub_sel_q[0], 4'b0000} +: 16]);
            ew_word: elem_o = rdata_q;
            default: elem_o = '0;
        endcase
    end

    assign elem_valid_o = valid_q;

endmodule

/* verilog/vreg_read_sequencer.sv */
module vreg_read_sequencer (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           cmd_valid_i,
    input  vreg_pkg::vread_cmd_t           cmd_i,
    output logic                           load_o,
    output vreg_pkg::start_list_t          start_list_o,
    output vreg_pkg::elem_width_e          ew_o,
    output vreg_pkg::walk_dir_e            dir_o,
    output logic [vreg_pkg::NUM_LANES-1:0] lane_mask_o,
    output logic                           step_o,
    output logic                           last_step_o,
    output logic                           busy_o
);
    import vreg_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_load,
        st_walk
    } seq_state_e;

    seq_state_e        state_q;
    vread_cmd_t        cmd_q;
    logic              cmd_accept;
    logic [CNT_W-1:0]  elem_limit;
    logic [STEP_W-1:0] n_m1;
    logic [STEP_W-1:0] cnt_q;
    logic              step_q;
    logic              last_q;
    logic [1:0]        drain_q;   // last step to last beat
    logic              busy_q;

    assign cmd_accept = cmd_valid_i && (state_q == st_idle) && !busy_q;

    always_comb begin
        case (cmd_q.ew)
            ew_byte: elem_limit = CNT_W'(CNT_LIMIT_BYTE);
            ew_half: elem_limit = CNT_W'(CNT_LIMIT_HALF);
            default: elem_limit = CNT_W'(CNT_LIMIT_WORD);
        endcase
        n_m1 = STEP_W'((int'(cmd_q.lmul_m1) + 1) * (int'(elem_limit) + 1) - 1);
    end

    // register r starts at r * VREG_LOC_PER_LANE
    always_comb begin
        logic [2:0] vreg_idx;
        start_list_o = '0;
        for (int s = 0; s < GROUP_MAX; s++) begin
            if (cmd_q.dir == dir_up) begin
                vreg_idx = cmd_q.vs + 3'(s);
                if (s <= int'(cmd_q.lmul_m1)) begin
                    start_list_o[s] = ADDR_W'(int'(vreg_idx) * VREG_LOC_PER_LANE);
                end
            end else begin
                // group packed into the top slots
                vreg_idx = cmd_q.vs + cmd_q.lmul_m1 + 3'(s) + 3'd1;
                if (s >= GROUP_MAX - 1 - int'(cmd_q.lmul_m1)) begin
                    start_list_o[s] = ADDR_W'(int'(vreg_idx) * VREG_LOC_PER_LANE);
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (cmd_accept) begin
            cmd_q <= cmd_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= st_idle;
            cnt_q   <= '0;
            step_q  <= 1'b0;
            last_q  <= 1'b0;
            drain_q <= '0;
            busy_q  <= 1'b0;
        end else begin
            step_q  <= 1'b0;
            last_q  <= 1'b0;
            drain_q <= {drain_q[0], last_q};
            case (state_q)
                st_idle: begin
                    if (cmd_accept) begin
                        state_q <= st_load;
                        busy_q  <= 1'b1;
                    end
                end
                st_load: begin
                    state_q <= st_walk;
                    cnt_q   <= n_m1;
                end
                st_walk: begin
                    step_q <= 1'b1;
                    if (cnt_q == '0) begin
                        last_q  <= 1'b1;
                        state_q <= st_idle;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                default: state_q <= st_idle;
            endcase
            if (drain_q[1]) begin
                busy_q <= 1'b0;
            end
        end
    end

    assign load_o      = (state_q == st_load);
    assign ew_o        = cmd_q.ew;
    assign dir_o       = cmd_q.dir;
    assign lane_mask_o = cmd_q.lane_mask;
    assign step_o      = step_q;
    assign last_step_o = last_q;
    assign busy_o      = busy_q;

    a_no_cmd_when_busy: assert property (
        @(posedge clk_i) disable iff (!rst_i) cmd_valid_i |-> !busy_q
    );

endmodule

/* verilog/vreg_result_collector.sv */
module vreg_result_collector (
    input  logic                                                clk_i,
    input  logic                                                rst_i,
    input  logic [vreg_pkg::NUM_LANES-1:0][vreg_pkg::ELEM_W-1:0] elem_i,
    input  logic [vreg_pkg::NUM_LANES-1:0]                      elem_valid_i,
    input  logic [vreg_pkg::NUM_LANES-1:0]                      lane_mask_i,
    input  logic                                                last_i,
    output logic                                                beat_valid_o,
    output vreg_pkg::vbeat_t                                    beat_o
);
    import vreg_pkg::*;

    logic [NUM_LANES-1:0] mask_d;   // aligned with lane data
    logic                 last_d;
    logic                 valid_q;
    vbeat_t               beat_q;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            mask_d  <= '0;
            last_d  <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            mask_d  <= lane_mask_i;
            last_d  <= last_i;
            valid_q <= elem_valid_i[0];
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < NUM_LANES; i++) begin
            beat_q.elem[i] <= mask_d[i] ? elem_i[i] : '0;
        end
        beat_q.last <= last_d && elem_valid_i[0];
    end

    assign beat_valid_o = valid_q;
    assign beat_o       = beat_q;

    // every lane is stepped by the same broadcast step
    a_lanes_in_step: assert property (
        @(posedge clk_i) disable iff (!rst_i)
        (elem_valid_i == '0) || (&elem_valid_i)
    );

endmodule

/* verilog/vreg_read_top.sv */
module vreg_read_top (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 cmd_valid_i,
    input  vreg_pkg::vread_cmd_t cmd_i,
    input  logic                 wr_valid_i,
    input  vreg_pkg::vwrite_t    wr_i,
    output logic                 beat_valid_o,
    output vreg_pkg::vbeat_t     beat_o,
    output logic                 busy_o
);
    import vreg_pkg::*;

    logic                             load;
    start_list_t                      start_list;
    elem_width_e                      ew;
    walk_dir_e                        dir;
    logic [NUM_LANES-1:0]             lane_mask;
    logic                             step;
    logic                             last_step;
    logic [NUM_LANES-1:0][ELEM_W-1:0] lane_elem;
    logic [NUM_LANES-1:0]             lane_valid;

    vreg_read_sequencer u_sequencer (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_i        (cmd_i),
        .load_o       (load),
        .start_list_o (start_list),
        .ew_o         (ew),
        .dir_o        (dir),
        .lane_mask_o  (lane_mask),
        .step_o       (step),
        .last_step_o  (last_step),
        .busy_o       (busy_o)
    );

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        vreg_lane #(
            .LANE_IDX (g)
        ) u_lane (
            .clk_i        (clk_i),
            .rst_i        (rst_i),
            .wr_valid_i   (wr_valid_i),
            .wr_i         (wr_i),
            .load_i       (load),
            .start_list_i (start_list),
            .ew_i         (ew),
            .dir_i        (dir),
            .step_i       (step),
            .lane_en_i    (lane_mask[g]),
            .elem_o       (lane_elem[g]),
            .elem_valid_o (lane_valid[g])
        );
    end

    vreg_result_collector u_collector (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .elem_i       (lane_elem),
        .elem_valid_i (lane_valid),
        .lane_mask_i  (lane_mask),
        .last_i       (last_step),
        .beat_valid_o (beat_valid_o),
        .beat_o       (beat_o)
    );

endmodule

/* tests/tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 20;   // 40 ns clock
    localparam int RESET_CYCLES = 16;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // active low, released on a falling edge
    initial begin
        rst_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b1;
    end

endmodule

/* tests/tb_vreg_read.sv */
module tb_vreg_read;
    timeunit 1ns;
    timeprecision 100ps;
    import vreg_pkg::*;

    // run length bound
    localparam int RESET_CYCLES   = 16 + 6;
    localparam int PRELOAD_CYCLES = 14 * NUM_LANES * VREG_LOC_PER_LANE;  // 14 registers
    localparam int BEAT_CYCLES    = 4 * 8 + 32 + 2 * 16 + 2 * 16 + 32 + 2 * 8 + 32;
    localparam int TEST_COUNT     = 6;
    localparam int CYCLE_LIMIT    = RESET_CYCLES + PRELOAD_CYCLES + BEAT_CYCLES
                                    + 40 * TEST_COUNT;

    logic       clk;
    logic       rst;
    logic       cmd_valid_i;
    vread_cmd_t cmd_i;
    logic       wr_valid_i;
    vwrite_t    wr_i;
    logic       beat_valid_o;
    vbeat_t     beat_o;
    logic       busy_o;

    logic [31:0] mem_model [NUM_LANES][MEM_DEPTH];   // mirror of lane memories
    int          seed = 32'h95b2_ef08;
    int          cycle_cnt = 0;

    tb_clock_gen u_clock_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    vreg_read_top dut_i (
        .clk_i        (clk),
        .rst_i        (rst),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_i        (cmd_i),
        .wr_valid_i   (wr_valid_i),
        .wr_i         (wr_i),
        .beat_valid_o (beat_valid_o),
        .beat_o       (beat_o),
        .busy_o       (busy_o)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("timeout, run exceeded %0d cycles", CYCLE_LIMIT);
            $display("Regression failed");
            $fatal(1, "simulation stopped by cycle limit");
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s: got %h expected %h", $time, name, got, exp);
            $display("Regression failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "stopping on protocol error");
    endtask

    function automatic int ew_bytes_of(input elem_width_e ew);
        if (ew == ew_byte) return 1;
        else if (ew == ew_half) return 2;
        return 4;
    endfunction

    // element k of a group walk as held in the mirror
    function automatic logic [31:0] expect_elem(input int lane, input int vs, input int lmul,
                                                input elem_width_e ew, input walk_dir_e dir,
                                                input int k);
        int          nbytes;
        int          e;
        int          epw;
        int          grp;
        int          j;
        int          r;
        int          sub;
        logic [31:0] word;
        logic [31:0] keep;
        nbytes = ew_bytes_of(ew);
        e      = VREG_LOC_PER_LANE * 4 / nbytes;
        epw    = 4 / nbytes;
        grp    = k / e;
        j      = k % e;
        if (dir == dir_up) begin
            r = (vs + grp) % NUM_VREGS;
        end else begin
            r = (vs + lmul - 1 - grp) % NUM_VREGS;
            j = e - 1 - j;   // descending inside the register
        end
        word = mem_model[lane][r * VREG_LOC_PER_LANE + j / epw];
        sub  = j % epw;
        keep = (nbytes == 4) ? 32'hffff_ffff : (32'h1 << (8 * nbytes)) - 32'h1;
        return (word >> (8 * nbytes * sub)) & keep;
    endfunction

    // random words for one register in every lane
    task automatic preload_reg(input int r);
        logic [31:0] data;
        int          addr;
        for (int lane = 0; lane < NUM_LANES; lane++) begin
            for (int w = 0; w < VREG_LOC_PER_LANE; w++) begin
                addr = r * VREG_LOC_PER_LANE + w;
                data = $random(seed);
                mem_model[lane][addr] = data;
                wr_i.lane  = LANE_W'(lane);
                wr_i.addr  = ADDR_W'(addr);
                wr_i.data  = data;
                wr_valid_i = 1'b1;
                @(negedge clk);
            end
        end
        wr_valid_i = 1'b0;
    endtask

    // issue one command and check every beat up to the negedge after the last beat
    task automatic run_read(input int vs, input int lmul, input elem_width_e ew,
                            input walk_dir_e dir, input logic [NUM_LANES-1:0] mask);
        int          n;
        int          wait_cnt;
        logic [31:0] exp;
        n = lmul * VREG_LOC_PER_LANE * 4 / ew_bytes_of(ew);
        check_value("busy_o before command", 32'(busy_o), 32'd0);
        cmd_i.vs        = 3'(vs);
        cmd_i.lmul_m1   = 3'(lmul - 1);
        cmd_i.ew        = ew;
        cmd_i.dir       = dir;
        cmd_i.lane_mask = mask;
        cmd_valid_i     = 1'b1;
        @(negedge clk);
        cmd_valid_i = 1'b0;
        wait_cnt    = 1;
        while (!beat_valid_o) begin
            check_value("busy_o before first beat", 32'(busy_o), 32'd1);
            if (wait_cnt > 20) begin
                abort_run("no beat arrived within 20 cycles of the command");
            end
            @(negedge clk);
            wait_cnt++;
        end
        check_value("first beat latency", 32'(wait_cnt), 32'd5);
        for (int k = 0; k < n; k++) begin
            check_value($sformatf("beat_valid_o beat %0d", k), 32'(beat_valid_o), 32'd1);
            check_value($sformatf("busy_o beat %0d", k), 32'(busy_o), 32'd1);
            check_value($sformatf("beat_o.last beat %0d", k), 32'(beat_o.last),
                        32'(k == n - 1));
            for (int l = 0; l < NUM_LANES; l++) begin
                exp = mask[l] ? expect_elem(l, vs, lmul, ew, dir, k) : 32'h0;
                check_value($sformatf("beat_o.elem[%0d] beat %0d", l, k),
                            beat_o.elem[l], exp);
            end
            @(negedge clk);
        end
        check_value("beat_valid_o after last beat", 32'(beat_valid_o), 32'd0);
        check_value("busy_o after last beat", 32'(busy_o), 32'd0);
    endtask

    task automatic reset_quiet;
        logic in_reset;
        in_reset = 1'b1;
        @(posedge clk);
        while (in_reset) begin
            @(negedge clk);
            check_value("busy_o in reset", 32'(busy_o), 32'd0);
            check_value("beat_valid_o in reset", 32'(beat_valid_o), 32'd0);
            @(posedge clk);
            in_reset = !rst;
        end
        repeat (4) begin
            @(negedge clk);
            check_value("busy_o when idle", 32'(busy_o), 32'd0);
            check_value("beat_valid_o when idle", 32'(beat_valid_o), 32'd0);
        end
    endtask

    task automatic word_reads_up;
        preload_reg(2);
        for (int r = 3; r <= 5; r++) begin
            preload_reg(r);
        end
        run_read(2, 1, ew_word, dir_up, 4'b1111);
        run_read(3, 3, ew_word, dir_up, 4'b1111);   // crosses two register boundaries
    endtask

    task automatic subword_reads_up;
        preload_reg(1);
        preload_reg(6);
        preload_reg(7);
        run_read(1, 1, ew_byte, dir_up, 4'b1111);
        run_read(6, 2, ew_half, dir_up, 4'b1111);
    endtask

    task automatic halfword_down_walk;
        preload_reg(5);
        preload_reg(6);
        run_read(5, 2, ew_half, dir_down, 4'b1111);
    endtask

    task automatic masked_lanes;
        preload_reg(0);
        preload_reg(3);
        run_read(0, 1, ew_byte, dir_up, 4'b1010);
    endtask

    task automatic back_to_back_reads;
        preload_reg(4);
        preload_reg(5);
        preload_reg(7);
        run_read(4, 2, ew_word, dir_up, 4'b1111);
        run_read(7, 1, ew_byte, dir_down, 4'b1111);   // issued as busy_o drops
    endtask

    initial begin
        cmd_valid_i = 1'b0;
        cmd_i       = '0;
        wr_valid_i  = 1'b0;
        wr_i        = '0;

        reset_quiet();
        word_reads_up();
        subword_reads_up();
        halfword_down_walk();
        masked_lanes();
        back_to_back_reads();

        $display("Regression passed");
        $finish;
    end

endmodule

/* all.f */
verilog/vreg_pkg.sv
verilog/vreg_addr_counter.sv
verilog/vreg_lane.sv
verilog/vreg_read_sequencer.sv
verilog/vreg_result_collector.sv
verilog/vreg_read_top.sv
tests/tb_clock_gen.sv
tests/tb_vreg_read.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_vreg_read -f all.f

./obj_dir/Vtb_vreg_read | tee sim.log

if grep -qx "Regression passed" sim.log; then
    echo "simulation ok"
else
    echo "simulation FAILED, see sim.log"
    exit 1
fi
